// File: build.f
source/memPkg.sv
source/dataMem.sv
source/accessDecode.sv
source/loadAlign.sv
source/fetchCounter.sv
source/bootLoader.sv
source/memSubsystem.sv
test/memSubsystem_props.sv
test/memSubsystemTb.sv

// File: Makefile
# Verilator simulation of the memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run counts as passed only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o $(TOP)
	$(OBJDIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/memSubsystemTb.sv
`timescale 1ns/100ps

module memSubsystemTb;

   localparam int bootWords = 64;
   localparam int fetchCycles = 100;
   localparam int isoOps = 24;      // load, dropped store, load
   localparam int wordOps = 200;
   localparam int mergeOps = 150;   // sub-word store then word load
   localparam int extOps = 150;
   localparam int misOps = 40;      // bad access then word load
   localparam int opCycles = fetchCycles + 3 * isoOps + wordOps + 2 * mergeOps
                             + extOps + 2 * misOps;
   localparam int timeoutNs = (bootWords + opCycles) * 10 * 4 + 10 * 10;

   logic clk;
   logic rst;
   logic bootValid;
   logic bootDone;
   logic busy;
   logic misaligned;
   logic running;                          // boot over, stores reach the model
   memPkg::word bootWord;
   memPkg::word rdata;
   memPkg::word instruction;
   memPkg::byteAddr pc;
   memPkg::lsuReq req;
   memPkg::word model [memPkg::memWords];  // reference memory
   logic [31:0] lfsrState;
   int checks;
   int errors;
   int checksAtStart;
   int errorsAtStart;

   memSubsystem DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns
   end

   initial begin
      #(timeoutNs);
      $display("watchdog expired after %0d ns, tests did not finish", timeoutNs);
      $display("Testbench failed");
      $finish;
   end

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      logic fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic memPkg::byteAddr randAddr(input logic [1:0] off);
      return {20'b0, 10'(randBits(10)), off};  // always inside the array
   endfunction

   function automatic int laneCount(input memPkg::accessSize size);
      case (size)
         memPkg::sizeByte: return 1;
         memPkg::sizeHalf: return 2;
         default: return 4;
      endcase
   endfunction

   function automatic logic placementLegal(input memPkg::byteAddr addr,
                                           input memPkg::accessSize size);
      if (addr >= 32'(memPkg::memWords * 4)) return 1'b0;  // past the end
      case (size)
         memPkg::sizeByte: return 1'b1;
         memPkg::sizeHalf: return addr[1:0] != 2'd3;
         memPkg::sizeWord: return addr[1:0] == 2'd0;
         default: return 1'b0;
      endcase
   endfunction

   // little-endian gather, then zero or sign fill
   function automatic memPkg::word expectedLoad(input memPkg::byteAddr addr,
                                                input memPkg::accessSize size, input logic uns);
      int nBytes;
      int off;
      memPkg::word val;
      nBytes = laneCount(size);
      off = int'(addr[1:0]);
      val = '0;
      for (int i = 0; i < nBytes; i++) begin
         val[i*8 +: 8] = model[addr[11:2]][(off+i)*8 +: 8];
      end
      if (!uns && nBytes < 4 && val[nBytes*8-1]) begin
         for (int b = nBytes * 8; b < 32; b++) begin
            val[b] = 1'b1;
         end
      end
      return val;
   endfunction

   function automatic void storeModel(input memPkg::byteAddr addr,
                                      input memPkg::accessSize size, input memPkg::word wdata);
      for (int i = 0; i < laneCount(size); i++) begin
         model[addr[11:2]][(int'(addr[1:0])+i)*8 +: 8] = wdata[i*8 +: 8];  // lane n gets byte i
      end
   endfunction

   task automatic checkValue(input string name, input memPkg::word got, input memPkg::word exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic finishTest(input string name);
      $display("%-22s %4d checks %3d errors", name, checks - checksAtStart,
               errors - errorsAtStart);
      checksAtStart = checks;
      errorsAtStart = errors;
   endtask

   // drive on the falling edge, sample at the rising edge
   task automatic access(input logic rd, input logic wr, input memPkg::byteAddr addr,
                         input memPkg::accessSize size, input logic uns,
                         input memPkg::word wdata, output memPkg::word got, output logic gotMis);
      @(negedge clk);
      req.read = rd;
      req.write = wr;
      req.addr = addr;
      req.size = size;
      req.isUnsigned = uns;
      req.wdata = wdata;
      @(posedge clk);
      got = rdata;     // load result does not move at this edge
      gotMis = misaligned;
      if (wr && running && placementLegal(addr, size)) storeModel(addr, size, wdata);
   endtask

   task automatic loadCheck(input memPkg::byteAddr addr, input memPkg::accessSize size,
                            input logic uns);
      memPkg::word got;
      memPkg::word exp;
      logic gotMis;
      exp = expectedLoad(addr, size, uns);
      access(1'b1, 1'b0, addr, size, uns, '0, got, gotMis);
      checkValue("rdata", got, exp);
      checkValue("misaligned", 32'(gotMis), 32'h0);
   endtask

   task automatic storeOnly(input memPkg::byteAddr addr, input memPkg::accessSize size,
                            input memPkg::word wdata);
      memPkg::word got;
      logic gotMis;
      access(1'b0, 1'b1, addr, size, 1'b0, wdata, got, gotMis);
      checkValue("misaligned", 32'(gotMis), 32'h0);
   endtask

   task automatic isolationTest();
      memPkg::byteAddr addr;
      for (int i = 0; i < isoOps; i++) begin
         addr = randAddr(2'd0);
         loadCheck(addr, memPkg::sizeWord, 1'b0);    // zero since reset
         storeOnly(addr, memPkg::sizeWord, randBits(32));
         loadCheck(addr, memPkg::sizeWord, 1'b0);    // store dropped while booting
         checkValue("busy", 32'(busy), 32'h1);
      end
      finishTest("reset and isolation");
   endtask

   task automatic bootFetchTest();
      memPkg::byteAddr expPc;
      for (int i = 0; i < bootWords; i++) begin
         @(negedge clk);
         req = '0;
         bootValid = 1'b1;
         bootWord = randBits(32);
         model[10'(i)] = bootWord;
      end
      @(negedge clk);
      bootValid = 1'b0;
      bootDone = 1'b1;
      @(negedge clk);
      bootDone = 1'b0;
      running = 1'b1;
      checkValue("busy", 32'(busy), 32'h0);
      expPc = '0;
      for (int c = 0; c < fetchCycles; c++) begin
         checkValue("pc", pc, expPc);
         checkValue("instruction", instruction, model[expPc[11:2]]);
         @(negedge clk);
         expPc = (expPc + 32'd4) & 32'h0000_0fff;  // counter wraps at 1024 words
      end
      finishTest("boot and fetch");
   endtask

   task automatic wordTrafficTest();
      memPkg::byteAddr addr;
      for (int i = 0; i < wordOps; i++) begin
         addr = randAddr(2'd0);
         if (randBits(1) != 0) storeOnly(addr, memPkg::sizeWord, randBits(32));
         else loadCheck(addr, memPkg::sizeWord, 1'b0);
      end
      finishTest("word traffic");
   endtask

   // byte or half at a legal offset, half never at 3
   task automatic subWordPick(output memPkg::byteAddr addr, output memPkg::accessSize size);
      logic [1:0] off;
      size = (randBits(1) != 0) ? memPkg::sizeHalf : memPkg::sizeByte;
      off = 2'(randBits(2));
      if (size == memPkg::sizeHalf && off == 2'd3) off = 2'(randBits(1));
      addr = randAddr(off);
   endtask

   task automatic mergeTest();
      memPkg::byteAddr addr;
      memPkg::accessSize size;
      for (int i = 0; i < mergeOps; i++) begin
         subWordPick(addr, size);
         storeOnly(addr, size, randBits(32));        // upper bytes of wdata ignored
         loadCheck({addr[31:2], 2'b00}, memPkg::sizeWord, 1'b0);
      end
      finishTest("sub-word merges");
   endtask

   task automatic extensionTest();
      memPkg::byteAddr addr;
      memPkg::accessSize size;
      for (int i = 0; i < extOps; i++) begin
         subWordPick(addr, size);
         loadCheck(addr, size, 1'(randBits(1)));
      end
      finishTest("load extension");
   endtask

   task automatic misalignTest();
      memPkg::byteAddr addr;
      memPkg::word got;
      logic gotMis;
      logic [1:0] kind;
      logic wr;
      for (int i = 0; i < misOps; i++) begin
         kind = 2'(randBits(2));                     // 0 is half at 3, else word at kind
         wr = 1'(randBits(1));
         addr = randAddr(kind == 2'd0 ? 2'd3 : kind);
         access(!wr, wr, addr, kind == 2'd0 ? memPkg::sizeHalf : memPkg::sizeWord, 1'b0,
                randBits(32), got, gotMis);
         checkValue("misaligned", 32'(gotMis), 32'h1);
         loadCheck({addr[31:2], 2'b00}, memPkg::sizeWord, 1'b0);  // row untouched
      end
      finishTest("misalignment");
   endtask

   initial begin
      lfsrState = 32'hb47e_030a;
      rst = 1'b1;
      bootValid = 1'b0;
      bootDone = 1'b0;
      bootWord = '0;
      req = '0;
      running = 1'b0;
      checks = 0;
      errors = 0;
      checksAtStart = 0;
      errorsAtStart = 0;
      model = '{default: '0};
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      isolationTest();          // before boot, memory still clear
      bootFetchTest();
      wordTrafficTest();
      mergeTest();
      extensionTest();
      misalignTest();
      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: test/memSubsystem_props.sv
`timescale 1ns/100ps

module memSubsystemProps (
   input logic             clk,
   input logic             rst,
   input logic             bootDone,
   input logic             busy,
   input logic             misaligned,
   input memPkg::wordIndex count,      // fetch counter
   input memPkg::memCmd    wrCmd       // memory write port
);

   holdBusy: assert property (@(posedge clk) disable iff (rst) busy && !bootDone |=> busy)
      else $error("busy dropped before bootDone");

   releaseBusy: assert property (@(posedge clk) disable iff (rst) busy && bootDone |=> !busy)
      else $error("busy still high after bootDone");

   // one fetch per cycle once running, wrap included
   countStep: assert property (@(posedge clk) disable iff (rst)
      !busy |=> count == memPkg::wordIndex'($past(count) + 1'b1))
      else $error("fetch counter did not advance by one");

   noMaskedWrite: assert property (@(posedge clk) disable iff (rst)
      misaligned && !busy |-> !(wrCmd.write && wrCmd.mask != '0))
      else $error("write with live mask during a misaligned access");

endmodule

bind memSubsystem memSubsystemProps props (
   .clk        (clk),
   .rst        (rst),
   .bootDone   (bootDone),
   .busy       (busy),
   .misaligned (misaligned),
   .count      (count),
   .wrCmd      (memWrCmd)
);

// File: source/memSubsystem.sv
`timescale 1ns/100ps

module memSubsystem (
   input  logic            clk,
   input  logic            rst,
   input  logic            bootValid,
   input  logic            bootDone,
   input  memPkg::word     bootWord,
   input  memPkg::lsuReq   req,
   output memPkg::word     rdata,
   output logic            misaligned,
   output logic            busy,
   output memPkg::byteAddr pc,
   output memPkg::word     instruction
);

   memPkg::memCmd decCmd;     // decoded core request
   memPkg::memCmd memWrCmd;   // write port after boot mux
   memPkg::wordIndex count;   // fetch / boot index
   memPkg::word rawData;      // row before lane select
   logic step;
   logic clear;

   // byte pc from word counter
   assign pc = {{(memPkg::byteAddrBits-memPkg::memIndexBits-2){1'b0}}, count, 2'b00};

   accessDecode decode (
      .req        (req),
      .cmd        (decCmd),
      .misaligned (misaligned)
   );

   bootLoader loader (
      .clk       (clk),
      .rst       (rst),
      .bootValid (bootValid),
      .bootDone  (bootDone),
      .bootWord  (bootWord),
      .count     (count),
      .decCmd    (decCmd),
      .wrCmd     (memWrCmd),
      .step      (step),
      .clear     (clear),
      .busy      (busy)
   );

   fetchCounter counter (
      .clk   (clk),
      .rst   (rst),
      .step  (step),
      .clear (clear),
      .count (count)
   );

   dataMem mem (
      .clk         (clk),
      .rst         (rst),
      .rdCmd       (decCmd),
      .wrCmd       (memWrCmd),
      .fetchIndex  (count),
      .rawData     (rawData),
      .instruction (instruction)
   );

   loadAlign align (
      .rawData    (rawData),
      .offset     (req.addr[1:0]),
      .size       (req.size),
      .isUnsigned (req.isUnsigned),
      .rdata      (rdata)
   );

endmodule

// File: source/bootLoader.sv
`timescale 1ns/100ps

module bootLoader (
   input  logic             clk,
   input  logic             rst,
   input  logic             bootValid,  // one word on bootWord
   input  logic             bootDone,   // end of the boot stream
   input  memPkg::word      bootWord,
   input  memPkg::wordIndex count,      // next boot row
   input  memPkg::memCmd    decCmd,     // decoded core access
   output memPkg::memCmd    wrCmd,      // to the memory write port
   output logic             step,
   output logic             clear,
   output logic             busy        // core must wait
);

   memPkg::loaderState state;
   memPkg::loaderState stateNext;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= memPkg::stLoading;
      end else begin
         state <= stateNext;
      end
   end

   // write port mux and counter control
   always_comb begin
      stateNext = state;
      clear = 1'b0;
      case (state)
         memPkg::stLoading: begin
            wrCmd.read = 1'b0;
            wrCmd.write = bootValid;
            wrCmd.index = count;                   // sequential fill
            wrCmd.mask = bootValid ? 4'b1111 : 4'b0000;
            wrCmd.wdata = bootWord;
            step = bootValid;                      // count follows each write
            busy = 1'b1;                           // core stores dropped here
            if (bootDone) begin
               stateNext = memPkg::stRunning;
               clear = 1'b1;                       // fetch restarts at 0
            end
         end
         default: begin
            wrCmd = decCmd;                        // core store path
            step = 1'b1;                           // one fetch per cycle
            busy = 1'b0;
         end
      endcase
   end

endmodule

// File: source/fetchCounter.sv
`timescale 1ns/100ps

module fetchCounter (
   input  logic             clk,
   input  logic             rst,
   input  logic             step,   // advance one word
   input  logic             clear,  // back to word 0, wins over step
   output memPkg::wordIndex count   // boot write index, then pc / 4
);

   // wraps at memWords through the index width
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (step) begin
         count <= count + 1'b1;
      end
   end

endmodule

// File: source/loadAlign.sv
`timescale 1ns/100ps

module loadAlign (
   input  memPkg::word       rawData,     // full row from memory
   input  logic [1:0]        offset,      // low address bits
   input  memPkg::accessSize size,
   input  logic              isUnsigned,  // lbu/lhu
   output memPkg::word       rdata
);

   memPkg::word shifted;  // addressed lanes moved down to bit 0
   logic signBit;         // top bit of the loaded field

   assign shifted = rawData >> {offset, 3'b000};

   always_comb begin
      signBit = 1'b0;
      case (size)
         memPkg::sizeByte: begin
            signBit = shifted[7] & ~isUnsigned;
            rdata = {{24{signBit}}, shifted[7:0]};  // lb/lbu
         end
         memPkg::sizeHalf: begin
            signBit = shifted[15] & ~isUnsigned;
            rdata = {{16{signBit}}, shifted[15:0]};  // lh/lhu
         end
         default: begin
            rdata = rawData;  // lw, no extension needed
         end
      endcase
   end

endmodule

// File: source/accessDecode.sv
`timescale 1ns/100ps

module accessDecode (
   input  memPkg::lsuReq req,
   output memPkg::memCmd cmd,
   output logic         misaligned
);

   logic [1:0] offset;          // byte within the word
   memPkg::byteMask laneMask;   // mask before the legality check
   logic placementOk;           // size/offset pair is allowed
   logic inRange;               // address falls inside the array
   logic active;                // a load or store is requested
   logic accept;                // request goes to memory

   assign offset = req.addr[1:0];
   assign inRange = (req.addr[memPkg::byteAddrBits-1:memPkg::memIndexBits+2] == '0);
   assign active = req.read | req.write;

   // lane mask by size and offset
   always_comb begin
      laneMask = '0;
      placementOk = 1'b0;
      case (req.size)
         memPkg::sizeByte: begin
            laneMask = memPkg::byteMask'(4'b0001 << offset);  // 1, 2, 4, 8
            placementOk = 1'b1;
         end
         memPkg::sizeHalf: begin
            laneMask = memPkg::byteMask'(4'b0011 << offset);  // 3, 6, 12
            placementOk = (offset != 2'd3);  // would straddle two words
         end
         memPkg::sizeWord: begin
            laneMask = 4'b1111;
            placementOk = (offset == 2'd0);  // words only at offset 0
         end
         default: begin
            laneMask = '0;  // unknown size never reaches memory
            placementOk = 1'b0;
         end
      endcase
   end

   assign accept = placementOk & inRange;
   assign misaligned = active & ~accept;  // only flagged for real requests

   assign cmd.read = req.read & accept;
   assign cmd.write = req.write & accept;
   assign cmd.index = req.addr[memPkg::memIndexBits+1:2];  // drop byte offset
   assign cmd.mask = accept ? laneMask : '0;
   assign cmd.wdata = req.wdata << {offset, 3'b000};  // little-endian lane shift

endmodule

// File: source/dataMem.sv
`timescale 1ns/100ps

module dataMem (
   input  logic           clk,
   input  logic           rst,
   input  memPkg::memCmd   rdCmd,        // load side, from the decoder
   input  memPkg::memCmd   wrCmd,        // write side, from the boot FSM
   input  memPkg::wordIndex fetchIndex,  // program counter as word index
   output memPkg::word     rawData,      // unaligned load word
   output memPkg::word     instruction   // fetched word
);

   memPkg::word mem [memPkg::memWords];  // unified instruction and data store

   // load port, no latency
   always_comb begin
      if (rdCmd.read) begin
         rawData = mem[rdCmd.index];     // full row, lanes picked later
      end else begin
         rawData = '0;                   // idle port reads zero
      end
   end

   assign instruction = mem[fetchIndex];  // fetch port, also combinational

   // byte-masked write, whole array cleared at reset
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mem <= '{default: '0};
      end else if (wrCmd.write) begin
         for (int lane = 0; lane < memPkg::byteLanes; lane++) begin
            if (wrCmd.mask[lane]) begin
               mem[wrCmd.index][lane*8 +: 8] <= wrCmd.wdata[lane*8 +: 8];  // lane in place
            end
         end
      end
   end

endmodule

// File: source/memPkg.sv
package memPkg;

   localparam int memIndexBits = 10;              // word index width
   localparam int memWords = 1 << memIndexBits;   // 1024 words, 4 KiB
   localparam int byteLanes = 4;                  // bytes per word
   localparam int byteAddrBits = 32;              // core-side address width

   typedef logic [31:0] word;                     // data or instruction word
   typedef logic [byteAddrBits-1:0] byteAddr;     // byte address, also pc
   typedef logic [memIndexBits-1:0] wordIndex;    // memory row
   typedef logic [byteLanes-1:0] byteMask;        // bit n enables byte n

   // load/store width as encoded by the core
   typedef enum logic [1:0] {
      sizeByte = 2'd0,
      sizeHalf = 2'd1,
      sizeWord = 2'd2
   } accessSize;

   // request from the core, sampled every cycle
   typedef struct packed {
      logic read;         // load strobe
      logic write;        // store strobe
      byteAddr addr;      // byte address
      accessSize size;    // byte, half or word
      logic isUnsigned;   // zero extension on loads
      word wdata;         // store data, right aligned
   } lsuReq;

   // command as seen by the memory array
   typedef struct packed {
      logic read;         // read enable
      logic write;        // write enable
      wordIndex index;    // row
      byteMask mask;      // lanes to update
      word wdata;         // data already in its lanes
   } memCmd;

   // boot state machine
   typedef enum logic {
      stLoading = 1'b0,   // memory filled from boot stream
      stRunning = 1'b1    // core owns the ports
   } loaderState;

endpackage
